// File: all.f
source/exe_pkg.sv
source/exe_op_if.sv
source/alu_unit.sv
source/branch_unit.sv
source/exe_retire_reg.sv
source/exe_stage.sv
verification/exe_stage_tb.sv

// File: Bender.yml
package:
  name: exe_stage

sources:
  - source/exe_pkg.sv
  - source/exe_op_if.sv
  - source/alu_unit.sv
  - source/branch_unit.sv
  - source/exe_retire_reg.sv
  - source/exe_stage.sv
  - target: test
    files:
      - verification/exe_stage_tb.sv

// File: verification/exe_stage_tb.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Execute stage testbench: random RV64I instructions against a reference
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module exe_stage_tb import exe_pkg::*; ();

  localparam int CLK_PERIOD   = 8;
  localparam int RESET_CYCLES = 3;
  localparam int NUM_INSTR    = 2000;
  localparam int WATCHDOG_NS  = (NUM_INSTR + RESET_CYCLES + 20) * CLK_PERIOD + 200;

  typedef struct packed {
    logic            rd_wen;
    logic [XLEN-1:0] rd_data;
    logic            pc_jmp;
    logic [XLEN-1:0] pc_jmpaddr;
    logic            flush;
    logic            memren;
    logic            memwen;
  } exp_t;

  logic            clock;
  logic            i_reset;
  logic            i_ena;
  logic            i_memren;
  logic            i_memwen;
  opcode_t         i_opcode;
  funct3_t         i_funct3;
  funct7_t         i_funct7;
  logic [XLEN-1:0] i_op1;
  logic [XLEN-1:0] i_op2;
  logic [XLEN-1:0] i_t1;
  logic [XLEN-1:0] i_pc_pred;
  logic            o_rd_wen;
  logic            o_pc_jmp;
  logic            o_flush;
  logic            o_memren;
  logic            o_memwen;
  logic [XLEN-1:0] o_rd_data;
  logic [XLEN-1:0] o_pc_jmpaddr;
  logic [31:0]     rng_state;
  exp_t            exp_q[$];

  exe_stage u_exe_stage (
    .clock        (clock),
    .i_reset      (i_reset),
    .i_ena        (i_ena),
    .i_opcode     (i_opcode),
    .i_funct3     (i_funct3),
    .i_funct7     (i_funct7),
    .i_op1        (i_op1),
    .i_op2        (i_op2),
    .i_t1         (i_t1),
    .i_pc_pred    (i_pc_pred),
    .i_memren     (i_memren),
    .i_memwen     (i_memwen),
    .o_rd_wen     (o_rd_wen),
    .o_rd_data    (o_rd_data),
    .o_pc_jmp     (o_pc_jmp),
    .o_pc_jmpaddr (o_pc_jmpaddr),
    .o_flush      (o_flush),
    .o_memren     (o_memren),
    .o_memwen     (o_memwen)
  );

  // two LCG steps, upper halves only since the low bits cycle quickly
  function automatic logic [31:0] next_rand();
    logic [15:0] hi;
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    hi = rng_state[31:16];
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return {hi, rng_state[31:16]};
  endfunction

  function automatic logic [XLEN-1:0] rand64();
    return {next_rand(), next_rand()};
  endfunction

  function automatic opcode_t pick_opcode(input int idx);
    case (idx)
      0: return OPCODE_LUI;
      1: return OPCODE_AUIPC;
      2: return OPCODE_OP_IMM;
      3: return OPCODE_JAL;
      4: return OPCODE_JALR;
      5: return OPCODE_BRANCH;
      6: return OPCODE_LOAD;
      7: return OPCODE_OP;
      8: return OPCODE_OP_IMM_32;
      9: return OPCODE_OP_32;
      default: return OPCODE_SYSTEM;
    endcase
  endfunction

  // arithmetic right shift built from a logical shift plus sign fill
  function automatic logic [XLEN-1:0] shift_right_arith(input logic [XLEN-1:0] a,
                                                        input logic [5:0] sh);
    logic [XLEN-1:0] r;
    r = a >> sh;
    if (a[XLEN-1])
      r = r | ~({XLEN{1'b1}} >> sh);
    return r;
  endfunction

  function automatic exp_t ref_model(input logic rst, input logic ena, input opcode_t opc,
                                     input funct3_t f3, input funct7_t f7,
                                     input logic [XLEN-1:0] a, input logic [XLEN-1:0] b,
                                     input logic [XLEN-1:0] t, input logic [XLEN-1:0] pred,
                                     input logic ren, input logic wen);
    exp_t e;
    logic [31:0] w;
    e = '0;
    if (rst || !ena)
      return e;
    e.memren = ren;
    e.memwen = wen;
    case (opc)
      OPCODE_LUI, OPCODE_SYSTEM: begin
        e.rd_wen  = 1'b1;
        e.rd_data = a;
      end
      OPCODE_AUIPC: begin
        e.rd_wen  = 1'b1;
        e.rd_data = a + b;
      end
      OPCODE_OP_IMM, OPCODE_OP: begin
        e.rd_wen = 1'b1;
        case (f3)
          F3_ADD:  e.rd_data = (opc == OPCODE_OP && f7[5]) ? a - b : a + b;
          F3_SLL:  e.rd_data = a << b[5:0];
          F3_SLT:  e.rd_data = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
          F3_SLTU: e.rd_data = (a < b) ? 64'd1 : 64'd0;
          F3_XOR:  e.rd_data = a ^ b;
          F3_SRL:  e.rd_data = f7[5] ? shift_right_arith(a, b[5:0]) : a >> b[5:0];
          F3_OR:   e.rd_data = a | b;
          default: e.rd_data = a & b;
        endcase
      end
      OPCODE_OP_IMM_32, OPCODE_OP_32: begin
        e.rd_wen = 1'b1;
        case (f3)
          F3_ADD:  w = (opc == OPCODE_OP_32 && f7[5]) ? a[31:0] - b[31:0] : a[31:0] + b[31:0];
          F3_SLL:  w = a[31:0] << b[4:0];
          // sign-extend the low word first, then shift by the 5-bit amount
          F3_SRL:  w = f7[5] ? shift_right_arith({{32{a[31]}}, a[31:0]}, {1'b0, b[4:0]})
                             : a[31:0] >> b[4:0];
          default: w = 32'd0;
        endcase
        e.rd_data = {{32{w[31]}}, w};
      end
      OPCODE_JAL: begin
        e.rd_wen     = 1'b1;
        e.rd_data    = a;
        e.pc_jmp     = 1'b1;
        e.pc_jmpaddr = b;
      end
      OPCODE_JALR: begin
        e.rd_wen     = 1'b1;
        e.rd_data    = t;
        e.pc_jmp     = 1'b1;
        e.pc_jmpaddr = (a + b) & ~64'd1;
      end
      OPCODE_BRANCH: begin
        e.pc_jmpaddr = t;
        case (f3)
          F3_BEQ:  e.pc_jmp = (a == b);
          F3_BNE:  e.pc_jmp = (a != b);
          F3_BLT:  e.pc_jmp = ($signed(a) < $signed(b));
          F3_BGE:  e.pc_jmp = ($signed(a) >= $signed(b));
          F3_BLTU: e.pc_jmp = (a < b);
          F3_BGEU: e.pc_jmp = (a >= b);
          default: e.pc_jmp = 1'b0;
        endcase
      end
      OPCODE_LOAD: e.rd_wen = 1'b1;
      default: e = e;
    endcase
    e.flush = e.pc_jmp && (e.pc_jmpaddr != pred);
    return e;
  endfunction

  task automatic check_value(input string name, input logic [XLEN-1:0] got,
                             input logic [XLEN-1:0] exp);
    if (got !== exp) begin
      $display("ERR %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
      $display("*** FAILED ***");
      $fatal(1, "output mismatch");
    end
  endtask

  task automatic queue_expected();
    exp_q.push_back(ref_model(i_reset, i_ena, i_opcode, i_funct3, i_funct7, i_op1, i_op2,
                              i_t1, i_pc_pred, i_memren, i_memwen));
  endtask

  task automatic drive_random_instr();
    logic [31:0] r;
    exp_t probe;
    r = next_rand();
    i_ena    = (r[2:0] != 3'd0);
    i_opcode = pick_opcode((r >> 8) % 11);
    i_funct3 = r[18:16];
    i_funct7 = {1'b0, r[19], 5'b0};
    i_t1     = rand64();
    i_op1    = rand64();
    // mix in equal and small operands so compares hit both sides
    case (r[21:20])
      2'd0: i_op2 = rand64();
      2'd1: i_op2 = i_op1;
      2'd2: begin
        i_op1 = {{56{r[26]}}, r[31:24]};
        i_op2 = {{56{r[27]}}, r[15:8]};
      end
      default: i_op2 = {{56{r[28]}}, r[7:0]};
    endcase
    i_memren = (r[23:22] == 2'd1);
    i_memwen = (r[23:22] == 2'd2);
    probe = ref_model(1'b0, 1'b1, i_opcode, i_funct3, i_funct7, i_op1, i_op2, i_t1,
                      '0, 1'b0, 1'b0);
    i_pc_pred = r[3] ? probe.pc_jmpaddr : rand64();
  endtask

  initial begin
    clock = 1'b0;
    forever #(CLK_PERIOD / 2) clock = ~clock;
  end

  initial begin : stimulus
    rng_state = 32'hdaf3;
    i_reset = 1'b1;
    i_ena = 1'b0;
    i_opcode = '0;
    i_funct3 = '0;
    i_funct7 = '0;
    i_op1 = '0;
    i_op2 = '0;
    i_t1 = '0;
    i_pc_pred = '0;
    i_memren = 1'b0;
    i_memwen = 1'b0;
    queue_expected();
    repeat (RESET_CYCLES - 1) begin
      @(negedge clock);
      queue_expected();
    end
    // idle cycles after reset, outputs must stay zero
    @(negedge clock);
    i_reset = 1'b0;
    queue_expected();
    @(negedge clock);
    queue_expected();
    repeat (NUM_INSTR) begin
      @(negedge clock);
      drive_random_instr();
      queue_expected();
    end
    @(negedge clock);
    i_ena = 1'b0;
    queue_expected();
    wait (exp_q.size() == 0);
    @(negedge clock);
    $display("*** PASSED ***");
    $finish;
  end

  // sample just after the edge, once the boundary register has settled
  initial begin : compare
    exp_t e;
    forever begin
      @(posedge clock);
      #1;
      if (exp_q.size() > 0) begin
        e = exp_q.pop_front();
        check_value("o_rd_wen", o_rd_wen, e.rd_wen);
        check_value("o_rd_data", o_rd_data, e.rd_data);
        check_value("o_pc_jmp", o_pc_jmp, e.pc_jmp);
        check_value("o_pc_jmpaddr", o_pc_jmpaddr, e.pc_jmpaddr);
        check_value("o_flush", o_flush, e.flush);
        check_value("o_memren", o_memren, e.memren);
        check_value("o_memwen", o_memwen, e.memwen);
      end
    end
  end

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("watchdog timeout, the run did not finish in time");
    $display("*** FAILED ***");
    $fatal(1, "timeout");
  end

endmodule

// File: source/exe_stage.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// RV64I execute stage top: ALU and branch unit feeding the boundary register
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module exe_stage import exe_pkg::*; (
  input  logic            clock,
  input  logic            i_reset,
  input  logic            i_ena,
  input  opcode_t         i_opcode,
  input  funct3_t         i_funct3,
  input  funct7_t         i_funct7,
  input  logic [XLEN-1:0] i_op1,
  input  logic [XLEN-1:0] i_op2,
  input  logic [XLEN-1:0] i_t1,
  input  logic [XLEN-1:0] i_pc_pred,
  input  logic            i_memren,
  input  logic            i_memwen,
  output logic            o_rd_wen,
  output logic [XLEN-1:0] o_rd_data,
  output logic            o_pc_jmp,
  output logic [XLEN-1:0] o_pc_jmpaddr,
  output logic            o_flush,
  output logic            o_memren,
  output logic            o_memwen
);

  alu_result_t  alu_res;
  jump_result_t jump_res;

  exe_op_if op_if ();

  // decoded instruction onto the shared bundle
  assign op_if.ena    = i_ena;
  assign op_if.opcode = i_opcode;
  assign op_if.funct3 = i_funct3;
  assign op_if.funct7 = i_funct7;
  assign op_if.op1    = i_op1;
  assign op_if.op2    = i_op2;
  assign op_if.t1     = i_t1;

  alu_unit u_alu_unit (
    .op    (op_if.alu),
    .o_alu (alu_res)
  );

  branch_unit u_branch_unit (
    .op     (op_if.br),
    .o_jump (jump_res)
  );

  exe_retire_reg u_exe_retire_reg (
    .clock        (clock),
    .i_reset      (i_reset),
    .i_ena        (i_ena),
    .i_alu        (alu_res),
    .i_jump       (jump_res),
    .i_pc_pred    (i_pc_pred),
    .i_memren     (i_memren),
    .i_memwen     (i_memwen),
    .o_rd_wen     (o_rd_wen),
    .o_rd_data    (o_rd_data),
    .o_pc_jmp     (o_pc_jmp),
    .o_pc_jmpaddr (o_pc_jmpaddr),
    .o_flush      (o_flush),
    .o_memren     (o_memren),
    .o_memwen     (o_memwen)
  );

endmodule

// File: source/exe_retire_reg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Execute/memory boundary: merges results, raises mispredict flush
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module exe_retire_reg import exe_pkg::*; (
  input  logic            clock,
  input  logic            i_reset,
  input  logic            i_ena,
  input  alu_result_t     i_alu,
  input  jump_result_t    i_jump,
  input  logic [XLEN-1:0] i_pc_pred,
  input  logic            i_memren,
  input  logic            i_memwen,
  output logic            o_rd_wen,
  output logic [XLEN-1:0] o_rd_data,
  output logic            o_pc_jmp,
  output logic [XLEN-1:0] o_pc_jmpaddr,
  output logic            o_flush,
  output logic            o_memren,
  output logic            o_memwen
);

  logic flush;

  // redirect only when the resolved target disagrees with fetch
  assign flush = i_jump.taken && (i_jump.target != i_pc_pred);

  always_ff @(posedge clock) begin
    if (i_reset || !i_ena) begin
      o_rd_wen     <= 1'b0;
      o_rd_data    <= '0;
      o_pc_jmp     <= 1'b0;
      o_pc_jmpaddr <= '0;
      o_flush      <= 1'b0;
      o_memren     <= 1'b0;
      o_memwen     <= 1'b0;
    end else begin
      o_rd_wen     <= i_alu.rd_wen;
      o_rd_data    <= i_alu.rd_data;
      o_pc_jmp     <= i_jump.taken;
      o_pc_jmpaddr <= i_jump.target;
      o_flush      <= flush;
      o_memren     <= i_memren;
      o_memwen     <= i_memwen;
    end
  end

  // a flush without a taken jump would redirect to garbage
  a_flush_needs_jmp : assert property (@(posedge clock) disable iff (i_reset)
    o_flush |-> o_pc_jmp);

  a_mem_onehot : assert property (@(posedge clock) disable iff (i_reset)
    !(o_memren && o_memwen));

  a_reset_clears : assert property (@(posedge clock)
    i_reset |=> (!o_rd_wen && !o_pc_jmp && !o_flush && !o_memren && !o_memwen
                 && o_rd_data == '0 && o_pc_jmpaddr == '0));

endmodule

// File: source/branch_unit.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Branch unit: evaluates branch conditions and selects the jump target
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module branch_unit import exe_pkg::*; (
  exe_op_if.br         op,
  output jump_result_t o_jump
);

  logic            eq;
  logic            lt_s;
  logic            lt_u;
  logic            cond;
  logic [XLEN-1:0] jalr_sum;
  logic            taken;
  logic [XLEN-1:0] target;

  // rs1 in op1, rs2 in op2
  assign eq       = op.op1 == op.op2;
  assign lt_s     = $signed(op.op1) < $signed(op.op2);
  assign lt_u     = op.op1 < op.op2;
  assign jalr_sum = op.op1 + op.op2;

  always_comb begin
    case (op.funct3)
      F3_BEQ:  cond = eq;
      F3_BNE:  cond = !eq;
      F3_BLT:  cond = lt_s;
      F3_BGE:  cond = !lt_s;
      F3_BLTU: cond = lt_u;
      F3_BGEU: cond = !lt_u;
      default: cond = 1'b0;
    endcase
  end

  always_comb begin
    taken  = 1'b0;
    target = '0;
    case (op.opcode)
      OPCODE_JAL: begin
        taken  = 1'b1;
        target = op.op2;
      end
      OPCODE_JALR: begin
        taken  = 1'b1;
        target = {jalr_sum[XLEN-1:1], 1'b0};
      end
      // target reported even when not taken
      OPCODE_BRANCH: begin
        taken  = cond;
        target = op.t1;
      end
      default: begin
        taken  = 1'b0;
        target = '0;
      end
    endcase
  end

  assign o_jump = '{taken: op.ena && taken, target: target};

endmodule

// File: source/alu_unit.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Integer ALU: rd value and write enable for every register-writing opcode
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module alu_unit import exe_pkg::*; (
  exe_op_if.alu       op,
  output alu_result_t o_alu
);

  logic            alt;
  logic            sub_sel;
  logic [XLEN-1:0] add_res;
  logic            lt_s;
  logic            lt_u;
  logic [5:0]      shamt;
  logic [4:0]      shamt_w;
  logic [XLEN-1:0] sll_res;
  logic [XLEN-1:0] srl_res;
  logic [XLEN-1:0] sra_res;
  logic [31:0]     sll_w;
  logic [31:0]     srl_w;
  logic [31:0]     sra_w;
  logic            rd_wen;
  logic [XLEN-1:0] rd_data;

  function automatic logic [XLEN-1:0] sext32(input logic [31:0] val);
    return {{(XLEN-32){val[31]}}, val};
  endfunction

  // funct7[5] picks SUB and SRA
  assign alt     = op.funct7[5];
  // immediate forms have no subtract, bit 5 there belongs to the imm
  assign sub_sel = alt && (op.opcode == OPCODE_OP || op.opcode == OPCODE_OP_32);

  // one adder for ADD/SUB, AUIPC and the W forms
  assign add_res = sub_sel ? (op.op1 - op.op2) : (op.op1 + op.op2);
  assign lt_s    = $signed(op.op1) < $signed(op.op2);
  assign lt_u    = op.op1 < op.op2;

  assign shamt   = op.op2[5:0];
  assign shamt_w = op.op2[4:0];
  assign sll_res = op.op1 << shamt;
  assign srl_res = op.op1 >> shamt;
  assign sra_res = $signed(op.op1) >>> shamt;

  // W shifts work on the low word only
  assign sll_w   = op.op1[31:0] << shamt_w;
  assign srl_w   = op.op1[31:0] >> shamt_w;
  assign sra_w   = $signed(op.op1[31:0]) >>> shamt_w;

  always_comb begin
    rd_wen  = 1'b0;
    rd_data = '0;
    case (op.opcode)
      OPCODE_LUI: begin
        rd_wen  = 1'b1;
        rd_data = op.op1;
      end
      OPCODE_AUIPC: begin
        rd_wen  = 1'b1;
        rd_data = add_res;
      end
      OPCODE_OP_IMM, OPCODE_OP: begin
        rd_wen = 1'b1;
        case (op.funct3)
          F3_ADD:  rd_data = add_res;
          F3_SLL:  rd_data = sll_res;
          F3_SLT:  rd_data = {{(XLEN-1){1'b0}}, lt_s};
          F3_SLTU: rd_data = {{(XLEN-1){1'b0}}, lt_u};
          F3_XOR:  rd_data = op.op1 ^ op.op2;
          F3_SRL:  rd_data = alt ? sra_res : srl_res;
          F3_OR:   rd_data = op.op1 | op.op2;
          F3_AND:  rd_data = op.op1 & op.op2;
          default: rd_data = '0;
        endcase
      end
      OPCODE_OP_IMM_32, OPCODE_OP_32: begin
        rd_wen = 1'b1;
        case (op.funct3)
          F3_ADD:  rd_data = sext32(add_res[31:0]);
          F3_SLL:  rd_data = sext32(sll_w);
          F3_SRL:  rd_data = sext32(alt ? sra_w : srl_w);
          default: rd_data = '0;
        endcase
      end
      // link value comes in op1 for JAL, t1 for JALR
      OPCODE_JAL: begin
        rd_wen  = 1'b1;
        rd_data = op.op1;
      end
      OPCODE_JALR: begin
        rd_wen  = 1'b1;
        rd_data = op.t1;
      end
      // memory stage supplies the load data later
      OPCODE_LOAD: begin
        rd_wen = 1'b1;
      end
      // old csr value goes to rd
      OPCODE_SYSTEM: begin
        rd_wen  = 1'b1;
        rd_data = op.op1;
      end
      default: begin
        rd_wen  = 1'b0;
        rd_data = '0;
      end
    endcase
  end

  assign o_alu = '{rd_wen: op.ena && rd_wen, rd_data: rd_data};

endmodule

// File: source/exe_op_if.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Decoded instruction bundle fanned out to the ALU and the branch unit
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

interface exe_op_if import exe_pkg::*; ();

  logic            ena;
  opcode_t         opcode;
  funct3_t         funct3;
  funct7_t         funct7;
  logic [XLEN-1:0] op1;
  logic [XLEN-1:0] op2;
  // jump target or link address, depending on opcode
  logic [XLEN-1:0] t1;

  modport drv (
    output ena, opcode, funct3, funct7, op1, op2, t1
  );

  modport alu (
    input ena, opcode, funct3, funct7, op1, op2, t1
  );

  // branch unit never looks at funct7
  modport br (
    input ena, opcode, funct3, op1, op2, t1
  );

endinterface

// File: source/exe_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Execute stage package: RV64I opcode and funct3 encodings, data width
// and the result records passed between the execute blocks
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package exe_pkg;

  // RV64I, the W forms tie this to 64
  localparam int XLEN = 64;

  typedef logic [6:0] opcode_t;
  typedef logic [2:0] funct3_t;
  typedef logic [6:0] funct7_t;

  // major opcodes, inst[6:0]
  localparam opcode_t OPCODE_LUI       = 7'b0110111;
  localparam opcode_t OPCODE_AUIPC     = 7'b0010111;
  localparam opcode_t OPCODE_OP_IMM    = 7'b0010011;
  localparam opcode_t OPCODE_JAL       = 7'b1101111;
  localparam opcode_t OPCODE_JALR      = 7'b1100111;
  localparam opcode_t OPCODE_BRANCH    = 7'b1100011;
  localparam opcode_t OPCODE_LOAD      = 7'b0000011;
  localparam opcode_t OPCODE_OP        = 7'b0110011;
  localparam opcode_t OPCODE_OP_IMM_32 = 7'b0011011;
  localparam opcode_t OPCODE_OP_32     = 7'b0111011;
  localparam opcode_t OPCODE_SYSTEM    = 7'b1110011;

  // integer ops, shared by the register and immediate forms
  localparam funct3_t F3_ADD  = 3'b000;
  localparam funct3_t F3_SLL  = 3'b001;
  localparam funct3_t F3_SLT  = 3'b010;
  localparam funct3_t F3_SLTU = 3'b011;
  localparam funct3_t F3_XOR  = 3'b100;
  localparam funct3_t F3_SRL  = 3'b101;
  localparam funct3_t F3_OR   = 3'b110;
  localparam funct3_t F3_AND  = 3'b111;

  // conditional branches
  localparam funct3_t F3_BEQ  = 3'b000;
  localparam funct3_t F3_BNE  = 3'b001;
  localparam funct3_t F3_BLT  = 3'b100;
  localparam funct3_t F3_BGE  = 3'b101;
  localparam funct3_t F3_BLTU = 3'b110;
  localparam funct3_t F3_BGEU = 3'b111;

  // destination register write from the ALU
  typedef struct packed {
    logic            rd_wen;
    logic [XLEN-1:0] rd_data;
  } alu_result_t;

  // resolved control transfer; target is valid even when not taken
  typedef struct packed {
    logic            taken;
    logic [XLEN-1:0] target;
  } jump_result_t;

endpackage
